// ==== Bender.yml ====
package:
  name: processorci

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/processorci_pkg.sv
      - logic/rv_decode.sv
      - logic/rv_execute.sv
      - logic/rv_result.sv
      - logic/rv_core.sv
      - logic/wb_bridge.sv
      - logic/processorci_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - dv/processorci_tb.sv

// ==== dv/processorci_tb.sv ====
`timescale 1ns/1ns

`include "processorci_params.svh"

module processorci_tb import processorci_pkg::*; ();
    localparam int PROG_LEN    = 200;
    localparam int WATCHDOG_NS = PROG_LEN * 6 * 6 * 10 + 200;
    localparam int T_RESET     = 0;
    localparam int T_FETCH     = 1;
    localparam int T_STORE     = 2;
    localparam int T_LOAD      = 3;
    localparam int T_X0        = 4;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic  sys_clk;
    logic  rst_i;
    logic  core_cyc_o;
    logic  core_stb_o;
    logic  core_we_o;
    word_t core_addr_o;
    word_t core_data_o;
    word_t core_data_i;
    logic  core_ack_i;

    logic [31:0] lcg_state = 32'h2160_209d;
    word_t       bus_mem [word_t];   // Program and data as seen on the bus
    word_t       model_mem [word_t];
    op_class_e   p_cls [PROG_LEN];   // Generated program, one entry per instruction
    alu_op_e     p_alu [PROG_LEN];
    logic        p_ne [PROG_LEN];
    reg_idx_t    p_rd [PROG_LEN];
    reg_idx_t    p_rs1 [PROG_LEN];
    reg_idx_t    p_rs2 [PROG_LEN];
    word_t       p_imm [PROG_LEN];
    int          gen_idx = 0;
    word_t       exp_fetch [$];
    word_t       exp_st_addr [$];
    word_t       exp_st_data [$];
    int          exp_st_test [$];    // Test that a store result belongs to
    int          fetch_cnt = 0;
    int          st_cnt = 0;
    int          stalled_acks = 0;
    int          delay_left = -1;
    int          err_cnt [5] = '{default: 0};
    int          tests_passed = 0;
    int          tests_failed = 0;

    processorci_top DUT (
        .sys_clk     (sys_clk),
        .rst_i       (rst_i),
        .core_cyc_o  (core_cyc_o),
        .core_stb_o  (core_stb_o),
        .core_we_o   (core_we_o),
        .core_addr_o (core_addr_o),
        .core_data_o (core_data_o),
        .core_data_i (core_data_i),
        .core_ack_i  (core_ack_i)
    );

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    function automatic word_t rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        word_t r;
        r = rand_word();
        return int'(r[30:16]) % n; // Upper bits, the low ones cycle fast
    endfunction

    function automatic word_t fill_word(input word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'hc3a5_0f96;
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Encode one instruction, place it in bus memory and keep its fields for the model
    task automatic emit(input op_class_e cls, input alu_op_e alu, input logic ne,
                        input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2,
                        input word_t imm);
        word_t      w;
        logic [2:0] f3;
        case (alu)
            ALU_XOR: f3 = 3'b100;
            ALU_OR:  f3 = 3'b110;
            ALU_AND: f3 = 3'b111;
            default: f3 = 3'b000;
        endcase
        case (cls)
            OP_LUI:    w = {imm[31:12], rd, OPC_LUI};
            OP_ALUI:   w = {imm[11:0], rs1, f3, rd, OPC_OPIMM};
            OP_ALU:    w = {(alu == ALU_SUB) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OPC_OP};
            OP_LOAD:   w = {imm[11:0], rs1, 3'b010, rd, OPC_LOAD};
            OP_STORE:  w = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
            OP_BRANCH: w = {imm[12], imm[10:5], rs2, rs1, 2'b00, ne, imm[4:1], imm[11],
                            OPC_BRANCH};
            default:   w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
        endcase
        bus_mem[`BOOT_ADDR + 4 * gen_idx] = w;
        p_cls[gen_idx] = cls;
        p_alu[gen_idx] = alu;
        p_ne[gen_idx]  = ne;
        p_rd[gen_idx]  = rd;
        p_rs1[gen_idx] = rs1;
        p_rs2[gen_idx] = rs2;
        p_imm[gen_idx] = imm;
        gen_idx++;
    endtask

    task automatic build_program();
        alu_op_e alu_tab [5] = '{ALU_ADD, ALU_AND, ALU_OR, ALU_XOR, ALU_SUB};
        int      kind, rd, rs, rt, sel, off, off2, skip, ne, ld, tgt;
        word_t   w;
        emit(OP_LUI, ALU_PASSB, 1'b0, 8, 0, 0, 32'h0000_2000); // Data base in x8
        for (int r = 1; r < 8; r++) begin
            w = rand_word();
            emit(OP_LUI, ALU_PASSB, 1'b0, r, 0, 0, {w[31:12], 12'h000});
            w = rand_word();
            emit(OP_ALUI, ALU_ADD, 1'b0, r, r, 0, sext12(w[11:0]));
        end
        while (gen_idx < PROG_LEN - 1) begin
            // All draws in fixed order so the program does not depend on the simulator
            kind = rand_below(10);
            rd   = rand_below(8);
            rs   = rand_below(8);
            rt   = rand_below(8);
            sel  = rand_below(5);
            off  = 4 * rand_below(16);
            off2 = 4 * rand_below(16);
            skip = rand_below(4);
            ne   = rand_below(2);
            ld   = 1 + rand_below(7);
            w    = rand_word();
            tgt  = gen_idx + 2 + skip;    // Always forward, past at least one slot
            if (tgt > PROG_LEN - 1) tgt = PROG_LEN - 1;
            case (kind)
                0, 1: emit(OP_ALU, alu_tab[sel], 1'b0, rd, rs, rt, '0);
                2, 3: emit(OP_ALUI, alu_tab[sel % 4], 1'b0, rd, rs, 0, sext12(w[11:0]));
                4:    emit(OP_LUI, ALU_PASSB, 1'b0, rd, 0, 0, {w[31:12], 12'h000});
                5, 6: emit(OP_STORE, ALU_ADD, 1'b0, 0, 8, rt, word_t'(off));
                7: begin
                    if (gen_idx + 3 < PROG_LEN) begin // Store, reload, store again
                        emit(OP_STORE, ALU_ADD, 1'b0, 0, 8, rt, word_t'(off));
                        emit(OP_LOAD, ALU_ADD, 1'b0, ld, 8, 0, word_t'(off));
                        emit(OP_STORE, ALU_ADD, 1'b0, 0, 8, ld, word_t'(off2));
                    end
                end
                8: emit(OP_BRANCH, ALU_SUB, ne[0], 0, rs, rt, word_t'(4 * (tgt - gen_idx)));
                default: emit(OP_JAL, ALU_ADD, 1'b0, rd, 0, 0, word_t'(4 * (tgt - gen_idx)));
            endcase
        end
        emit(OP_JAL, ALU_ADD, 1'b0, 0, 0, 0, '0); // Park in a loop on itself
    endtask

    // Instruction-level model giving the fetch sequence and the store list
    task automatic run_model();
        word_t regs [32];
        bit    loaded [32];
        word_t pc, npc, a, b, res, addr;
        int    idx;
        logic  wr;
        foreach (regs[i]) begin
            regs[i]   = '0;
            loaded[i] = 1'b0;
        end
        pc = `BOOT_ADDR;
        while (1) begin
            idx = (pc - `BOOT_ADDR) / 4;
            exp_fetch.push_back(pc);
            if (idx == PROG_LEN - 1) break;
            a   = regs[p_rs1[idx]];
            b   = (p_cls[idx] == OP_ALU) ? regs[p_rs2[idx]] : p_imm[idx];
            npc = pc + 4;
            wr  = 1'b1;
            res = '0;
            case (p_cls[idx])
                OP_LUI: res = p_imm[idx];
                OP_ALU, OP_ALUI: begin
                    case (p_alu[idx])
                        ALU_SUB: res = a - b;
                        ALU_AND: res = a & b;
                        ALU_OR:  res = a | b;
                        ALU_XOR: res = a ^ b;
                        default: res = a + b;
                    endcase
                end
                OP_LOAD: begin
                    addr = a + p_imm[idx];
                    res  = model_mem.exists(addr) ? model_mem[addr] : fill_word(addr);
                end
                OP_STORE: begin
                    wr   = 1'b0;
                    addr = a + p_imm[idx];
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(regs[p_rs2[idx]]);
                    if (p_rs2[idx] == 0) exp_st_test.push_back(T_X0);
                    else if (loaded[p_rs2[idx]]) exp_st_test.push_back(T_LOAD);
                    else exp_st_test.push_back(T_STORE);
                    model_mem[addr] = regs[p_rs2[idx]];
                end
                OP_BRANCH: begin
                    wr = 1'b0;
                    if ((a != regs[p_rs2[idx]]) == p_ne[idx]) npc = pc + p_imm[idx];
                end
                default: begin
                    res = pc + 4; // JAL link
                    npc = pc + p_imm[idx];
                end
            endcase
            if (wr && p_rd[idx] != 0) begin
                regs[p_rd[idx]]   = res;
                loaded[p_rd[idx]] = (p_cls[idx] == OP_LOAD);
            end
            pc = npc;
        end
    endtask

    task automatic check_fetch(input word_t addr);
        if (fetch_cnt < exp_fetch.size()) begin
            assert (addr == exp_fetch[fetch_cnt]) else begin
                $display("Error: %0t ns core_addr_o fetch %0d got %h expected %h",
                         $time, fetch_cnt, addr, exp_fetch[fetch_cnt]);
                err_cnt[T_FETCH]++;
            end
            fetch_cnt++;
        end
    endtask

    task automatic check_store(input word_t addr, input word_t data);
        int t;
        if (st_cnt >= exp_st_addr.size()) begin
            $display("Store to %h at %0t ns is beyond the end of the expected store list",
                     addr, $time);
            err_cnt[T_STORE]++;
        end else begin
            t = exp_st_test[st_cnt];
            assert (addr == exp_st_addr[st_cnt]) else begin
                $display("Error: %0t ns core_addr_o store %0d got %h expected %h",
                         $time, st_cnt, addr, exp_st_addr[st_cnt]);
                err_cnt[t]++;
            end
            assert (data == exp_st_data[st_cnt]) else begin
                $display("Error: %0t ns core_data_o store %0d got %h expected %h",
                         $time, st_cnt, data, exp_st_data[st_cnt]);
                err_cnt[t]++;
            end
            st_cnt++;
        end
    endtask

    // Wishbone slave with 0 to 4 wait cycles per access
    always @(posedge sys_clk) begin
        if (rst_i) begin
            core_ack_i <= 1'b0;
            delay_left = -1;
        end else begin
            core_ack_i <= 1'b0;
            if (core_cyc_o && core_stb_o && !core_ack_i) begin
                if (delay_left < 0) begin
                    delay_left = rand_below(5); // New access
                    if (delay_left > 0) stalled_acks++;
                end
                if (delay_left == 0) begin
                    core_ack_i <= 1'b1;
                    delay_left = -1;
                    if (core_we_o) begin
                        check_store(core_addr_o, core_data_o);
                        bus_mem[core_addr_o] = core_data_o;
                    end else begin
                        core_data_i <= bus_mem.exists(core_addr_o) ?
                                       bus_mem[core_addr_o] : fill_word(core_addr_o);
                        if (core_addr_o >= `BOOT_ADDR && core_addr_o < `BOOT_ADDR + 4 * PROG_LEN)
                            check_fetch(core_addr_o);
                    end
                end else begin
                    delay_left--;
                end
            end
        end
    end

    task automatic report_test(input int t, input string name);
        if (err_cnt[t] == 0) begin
            tests_passed++;
            $display("Test %-20s passed", name);
        end else begin
            tests_failed++;
            $display("Test %-20s failed with %0d errors", name, err_cnt[t]);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with %0d of %0d fetches seen",
                 WATCHDOG_NS, fetch_cnt, exp_fetch.size());
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int cycles;
        rst_i       = 1'b1;
        core_ack_i  = 1'b0;
        core_data_i = '0;
        build_program();
        run_model();
        for (int i = 0; i < 3; i++) begin
            @(posedge sys_clk);
            if (i == 2) begin
                rst_i <= 1'b0;
            end else begin
                @(negedge sys_clk);
                assert (!core_cyc_o && !core_stb_o && !core_we_o) else begin
                    $display("Bus control outputs are not low during reset at %0t ns", $time);
                    err_cnt[T_RESET]++;
                end
            end
        end
        cycles = 0;
        @(negedge sys_clk);
        while (!core_stb_o && cycles < 8) begin
            @(negedge sys_clk);
            cycles++;
        end
        assert (core_stb_o && !core_we_o) else begin
            $display("No read cycle started within 8 cycles after reset");
            err_cnt[T_RESET]++;
        end
        assert (core_addr_o == `BOOT_ADDR) else begin
            $display("Error: %0t ns core_addr_o got %h expected %h",
                     $time, core_addr_o, `BOOT_ADDR);
            err_cnt[T_RESET]++;
        end
        report_test(T_RESET, "reset");

        while (fetch_cnt < exp_fetch.size()) @(negedge sys_clk);
        assert (st_cnt == exp_st_addr.size()) else begin
            $display("Only %0d of %0d expected stores were seen", st_cnt, exp_st_addr.size());
            err_cnt[T_STORE]++;
        end
        assert (stalled_acks > 0) else begin
            $display("No access was stalled, back-pressure was never exercised");
            err_cnt[T_X0]++;
        end
        report_test(T_FETCH, "fetch order");
        report_test(T_STORE, "stores");
        report_test(T_LOAD, "loads");
        report_test(T_X0, "x0 and back-pressure");
        $display("Tests passed %0d, failed %0d, fetches %0d, stores %0d, stalled acks %0d",
                 tests_passed, tests_failed, fetch_cnt, st_cnt, stalled_acks);
        if (tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== include/processorci_params.svh ====
`ifndef PROCESSORCI_PARAMS_SVH
`define PROCESSORCI_PARAMS_SVH

// Data and address width
`define XLEN 32

// Register index width
`define REG_ADDR_W 5

// Architectural registers, x0 included
`define NUM_REGS 32

// Reset PC
`define BOOT_ADDR 32'h0000_1000

`endif

// ==== logic/processorci_pkg.sv ====
`include "processorci_params.svh"

package processorci_pkg;

    // Data or address word
    typedef logic [`XLEN-1:0] word_t;

    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    // Operation class out of the decoder
    typedef enum logic [2:0] {
        OP_LUI,
        OP_ALUI,     // Register-immediate ALU
        OP_ALU,      // Register-register ALU
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_JAL,
        OP_ILLEGAL
    } op_class_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASSB    // Operand b straight through, used by LUI
    } alu_op_e;

    // Core sequencer states
    typedef enum logic [2:0] {
        ST_FETCH,
        ST_FETCH_WAIT,
        ST_EXEC,
        ST_MEM,
        ST_MEM_WAIT,
        ST_WB
    } core_state_e;

endpackage

// ==== logic/processorci_top.sv ====
`timescale 1ns/1ns

module processorci_top import processorci_pkg::*; (
    input  logic  sys_clk,
    input  logic  rst_i,
    output logic  core_cyc_o,
    output logic  core_stb_o,
    output logic  core_we_o,
    output word_t core_addr_o,
    output word_t core_data_o,
    input  word_t core_data_i,
    input  logic  core_ack_i
);
    // Core request side
    logic  mem_req;
    logic  mem_we;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_gnt;
    logic  mem_rvalid;
    word_t mem_rdata;

    rv_core u_core (
        .sys_clk      (sys_clk),
        .rst_i        (rst_i),
        .mem_req_o    (mem_req),
        .mem_we_o     (mem_we),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_gnt_i    (mem_gnt),
        .mem_rvalid_i (mem_rvalid),
        .mem_rdata_i  (mem_rdata)
    );

    wb_bridge u_bridge (
        .sys_clk      (sys_clk),
        .rst_i        (rst_i),
        .mem_req_i    (mem_req),
        .mem_we_i     (mem_we),
        .mem_addr_i   (mem_addr),
        .mem_wdata_i  (mem_wdata),
        .mem_gnt_o    (mem_gnt),
        .mem_rvalid_o (mem_rvalid),
        .mem_rdata_o  (mem_rdata),
        .core_cyc_o   (core_cyc_o),
        .core_stb_o   (core_stb_o),
        .core_we_o    (core_we_o),
        .core_addr_o  (core_addr_o),
        .core_data_o  (core_data_o),
        .core_data_i  (core_data_i),
        .core_ack_i   (core_ack_i)
    );

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ns

`include "processorci_params.svh"

module rv_core import processorci_pkg::*; (
    input  logic  sys_clk,
    input  logic  rst_i,
    output logic  mem_req_o,
    output logic  mem_we_o,
    output word_t mem_addr_o,
    output word_t mem_wdata_o,
    input  logic  mem_gnt_i,
    input  logic  mem_rvalid_i,
    input  word_t mem_rdata_i
);
    core_state_e state_q;
    core_state_e state_d;
    word_t       pc_q;
    word_t       ir_q;       // Instruction register
    word_t       load_q;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    word_t       imm;
    op_class_e   op_class;
    alu_op_e     alu_op;
    logic        branch_ne;
    logic        rd_we;
    word_t       rs1_val;
    word_t       rs2_val;
    word_t       alu_res;
    word_t       next_pc;
    word_t       data_addr;
    word_t       link;
    logic        is_mem_op;

    assign is_mem_op = (op_class == OP_LOAD) || (op_class == OP_STORE);
    assign link      = pc_q + 32'd4;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_FETCH: begin
                if (mem_gnt_i) state_d = ST_FETCH_WAIT;
            end
            ST_FETCH_WAIT: begin
                if (mem_rvalid_i) state_d = ST_EXEC;
            end
            ST_EXEC: begin
                state_d = is_mem_op ? ST_MEM : ST_WB;
            end
            ST_MEM: begin
                if (mem_gnt_i) state_d = ST_MEM_WAIT;
            end
            ST_MEM_WAIT: begin
                if (mem_rvalid_i) state_d = ST_WB;
            end
            default: state_d = ST_FETCH; // ST_WB retires and refetches
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            state_q <= ST_FETCH;
            pc_q    <= `BOOT_ADDR;
        end else begin
            state_q <= state_d;
            if (state_q == ST_WB) pc_q <= next_pc;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state_q == ST_FETCH_WAIT && mem_rvalid_i) ir_q <= mem_rdata_i;
        if (state_q == ST_MEM_WAIT && mem_rvalid_i) load_q <= mem_rdata_i;
    end

    // Request side, held by the state until the grant
    assign mem_req_o   = (state_q == ST_FETCH) || (state_q == ST_MEM);
    assign mem_we_o    = (state_q == ST_MEM) && (op_class == OP_STORE);
    assign mem_addr_o  = (state_q == ST_MEM) ? data_addr : pc_q;
    assign mem_wdata_o = rs2_val;

    rv_decode u_decode (
        .instr_i     (ir_q),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rd_o        (rd),
        .imm_o       (imm),
        .op_class_o  (op_class),
        .alu_op_o    (alu_op),
        .branch_ne_o (branch_ne),
        .rd_we_o     (rd_we)
    );

    rv_execute u_execute (
        .op_class_i  (op_class),
        .alu_op_i    (alu_op),
        .branch_ne_i (branch_ne),
        .pc_i        (pc_q),
        .rs1_val_i   (rs1_val),
        .rs2_val_i   (rs2_val),
        .imm_i       (imm),
        .alu_res_o   (alu_res),
        .next_pc_o   (next_pc),
        .mem_addr_o  (data_addr)
    );

    rv_result u_result (
        .sys_clk     (sys_clk),
        .rst_i       (rst_i),
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .rd_i        (rd),
        .rd_we_i     (rd_we && (state_q == ST_WB)), // Single write per instruction
        .wb_sel_i    (op_class),
        .alu_res_i   (alu_res),
        .load_data_i (load_q),
        .link_i      (link),
        .rs1_val_o   (rs1_val),
        .rs2_val_o   (rs2_val)
    );

    // Request and its address stay put until the bridge takes them
    assert property (@(posedge sys_clk) disable iff (rst_i)
        (mem_req_o && !mem_gnt_i) |=> (mem_req_o && $stable(mem_addr_o)))
        else $error("rv_core: request dropped or changed before grant");

endmodule

// ==== logic/rv_decode.sv ====
`timescale 1ns/1ns

module rv_decode import processorci_pkg::*; (
    input  word_t     instr_i,
    output reg_idx_t  rs1_o,
    output reg_idx_t  rs2_o,
    output reg_idx_t  rd_o,
    output word_t     imm_o,
    output op_class_e op_class_o,
    output alu_op_e   alu_op_o,
    output logic      branch_ne_o,
    output logic      rd_we_o
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i_type;
    word_t      imm_s_type;
    word_t      imm_b_type;
    word_t      imm_u_type;
    word_t      imm_j_type;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];
    assign rd_o  = instr_i[11:7];

    // Immediate formats, all sign extended from bit 31
    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};

    always_comb begin
        op_class_o  = OP_ILLEGAL; // Anything unmatched retires as a no-op
        alu_op_o    = ALU_ADD;
        imm_o       = imm_i_type;
        branch_ne_o = funct3[0];
        rd_we_o     = 1'b0;
        case (opcode)
            7'b0110111: begin
                op_class_o = OP_LUI;
                alu_op_o   = ALU_PASSB;
                imm_o      = imm_u_type;
                rd_we_o    = 1'b1;
            end
            7'b0010011: begin
                // Only ADDI, XORI, ORI, ANDI
                if (funct3 == 3'b000 || funct3 == 3'b100 || funct3[2:1] == 2'b11) begin
                    op_class_o = OP_ALUI;
                    rd_we_o    = 1'b1;
                end
                case (funct3)
                    3'b100:  alu_op_o = ALU_XOR;
                    3'b110:  alu_op_o = ALU_OR;
                    3'b111:  alu_op_o = ALU_AND;
                    default: alu_op_o = ALU_ADD;
                endcase
            end
            7'b0110011: begin
                if (funct7 == 7'b0000000 &&
                    (funct3 == 3'b000 || funct3 == 3'b100 || funct3[2:1] == 2'b11)) begin
                    op_class_o = OP_ALU;
                    rd_we_o    = 1'b1;
                    case (funct3)
                        3'b100:  alu_op_o = ALU_XOR;
                        3'b110:  alu_op_o = ALU_OR;
                        3'b111:  alu_op_o = ALU_AND;
                        default: alu_op_o = ALU_ADD;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    op_class_o = OP_ALU; // SUB
                    alu_op_o   = ALU_SUB;
                    rd_we_o    = 1'b1;
                end
            end
            7'b0000011: begin
                if (funct3 == 3'b010) begin // LW only
                    op_class_o = OP_LOAD;
                    rd_we_o    = 1'b1;
                end
            end
            7'b0100011: begin
                imm_o = imm_s_type;
                if (funct3 == 3'b010) begin
                    op_class_o = OP_STORE;
                end
            end
            7'b1100011: begin
                imm_o    = imm_b_type;
                alu_op_o = ALU_SUB;
                if (funct3[2:1] == 2'b00) begin // BEQ or BNE
                    op_class_o = OP_BRANCH;
                end
            end
            7'b1101111: begin
                op_class_o = OP_JAL;
                imm_o      = imm_j_type;
                rd_we_o    = 1'b1;
            end
            default: ;
        endcase
    end

    // Sampled on every new instruction word
    assert property (@(instr_i) (op_class_o == OP_ILLEGAL) |-> !rd_we_o)
        else $error("rv_decode: illegal encoding with rd write enable");

endmodule

// ==== logic/rv_execute.sv ====
`timescale 1ns/1ns

module rv_execute import processorci_pkg::*; (
    input  op_class_e op_class_i,
    input  alu_op_e   alu_op_i,
    input  logic      branch_ne_i,
    input  word_t     pc_i,
    input  word_t     rs1_val_i,
    input  word_t     rs2_val_i,
    input  word_t     imm_i,
    output word_t     alu_res_o,
    output word_t     next_pc_o,
    output word_t     mem_addr_o
);
    word_t operand_b;
    word_t pc_plus4;
    word_t pc_target;
    logic  rs_equal;
    logic  branch_taken;

    // Register operand only for R-type
    assign operand_b = (op_class_i == OP_ALU) ? rs2_val_i : imm_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:   alu_res_o = rs1_val_i + operand_b;
            ALU_SUB:   alu_res_o = rs1_val_i - operand_b;
            ALU_AND:   alu_res_o = rs1_val_i & operand_b;
            ALU_OR:    alu_res_o = rs1_val_i | operand_b;
            ALU_XOR:   alu_res_o = rs1_val_i ^ operand_b;
            ALU_PASSB: alu_res_o = operand_b;
            default:   alu_res_o = rs1_val_i + operand_b;
        endcase
    end

    assign rs_equal     = (rs1_val_i == rs2_val_i);
    assign branch_taken = branch_ne_i ? !rs_equal : rs_equal; // BNE : BEQ

    assign pc_plus4  = pc_i + 32'd4;
    assign pc_target = pc_i + imm_i; // Shared by branch and JAL

    always_comb begin
        case (op_class_i)
            OP_BRANCH: next_pc_o = branch_taken ? pc_target : pc_plus4;
            OP_JAL:    next_pc_o = pc_target;
            default:   next_pc_o = pc_plus4;
        endcase
    end

    // Word address for LW and SW
    assign mem_addr_o = rs1_val_i + imm_i;

endmodule

// ==== logic/rv_result.sv ====
`timescale 1ns/1ns

`include "processorci_params.svh"

module rv_result import processorci_pkg::*; (
    input  logic      sys_clk,
    input  logic      rst_i,
    input  reg_idx_t  rs1_i,
    input  reg_idx_t  rs2_i,
    input  reg_idx_t  rd_i,
    input  logic      rd_we_i,
    input  op_class_e wb_sel_i,
    input  word_t     alu_res_i,
    input  word_t     load_data_i,
    input  word_t     link_i,
    output word_t     rs1_val_o,
    output word_t     rs2_val_o
);
    // Storage for x1 to x31 only as x0 has none
    word_t regs [1:`NUM_REGS-1];
    word_t wb_data;

    always_comb begin
        case (wb_sel_i)
            OP_LOAD: wb_data = load_data_i;
            OP_JAL:  wb_data = link_i;     // Return address
            default: wb_data = alu_res_i;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we_i && rd_i != '0) begin
            regs[rd_i] <= wb_data;
        end
    end

    // Asynchronous read ports
    assign rs1_val_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_val_o = (rs2_i == '0) ? '0 : regs[rs2_i];

    // A write-back aimed at x0 leaves the register read on rs1 as it was
    assert property (@(posedge sys_clk) disable iff (rst_i)
        (rd_we_i && rd_i == '0) |=> (rs1_i != $past(rs1_i) || $stable(rs1_val_o)))
        else $error("rv_result: register changed after a write to rd 0");

endmodule

// ==== logic/wb_bridge.sv ====
`timescale 1ns/1ns

module wb_bridge import processorci_pkg::*; (
    input  logic  sys_clk,
    input  logic  rst_i,
    input  logic  mem_req_i,
    input  logic  mem_we_i,
    input  word_t mem_addr_i,
    input  word_t mem_wdata_i,
    output logic  mem_gnt_o,
    output logic  mem_rvalid_o,
    output word_t mem_rdata_o,
    output logic  core_cyc_o,
    output logic  core_stb_o,
    output logic  core_we_o,
    output word_t core_addr_o,
    output word_t core_data_o,
    input  word_t core_data_i,
    input  logic  core_ack_i
);
    typedef enum logic {
        BR_IDLE,
        BR_BUSY
    } bridge_state_e;

    bridge_state_e state_q;
    logic          cyc_q;
    logic          stb_q;
    logic          we_q;
    logic          rvalid_q;
    word_t         addr_q;
    word_t         wdata_q;
    word_t         rdata_q;

    // Accept straight away whenever no cycle is open
    assign mem_gnt_o = mem_req_i && (state_q == BR_IDLE);

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            state_q  <= BR_IDLE;
            cyc_q    <= 1'b0;
            stb_q    <= 1'b0;
            we_q     <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= 1'b0;
            case (state_q)
                BR_IDLE: begin
                    if (mem_gnt_o) begin
                        state_q <= BR_BUSY;
                        cyc_q   <= 1'b1;
                        stb_q   <= 1'b1;
                        we_q    <= mem_we_i;
                    end
                end
                default: begin
                    if (core_ack_i) begin // Slave may stall for any number of cycles
                        state_q  <= BR_IDLE;
                        cyc_q    <= 1'b0;
                        stb_q    <= 1'b0;
                        we_q     <= 1'b0;
                        rvalid_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (mem_gnt_o) begin
            addr_q  <= mem_addr_i;
            wdata_q <= mem_wdata_i;
        end
        if (state_q == BR_BUSY && core_ack_i) rdata_q <= core_data_i;
    end

    assign core_cyc_o   = cyc_q;
    assign core_stb_o   = stb_q;
    assign core_we_o    = we_q;
    assign core_addr_o  = addr_q;
    assign core_data_o  = wdata_q;
    assign mem_rvalid_o = rvalid_q;
    assign mem_rdata_o  = rdata_q;

    // Strobe stays inside the cycle and holds its request until the ack
    assert property (@(posedge sys_clk) disable iff (rst_i)
        (core_stb_o && !core_ack_i) |=>
            (core_cyc_o && core_stb_o && $stable(core_addr_o) && $stable(core_we_o) &&
             (!core_we_o || $stable(core_data_o))))
        else $error("wb_bridge: bus cycle dropped or changed before ack");

endmodule

// ==== sim.f ====
+incdir+include
logic/processorci_pkg.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_core.sv
logic/wb_bridge.sv
logic/processorci_top.sv
dv/processorci_tb.sv
